/* logic/clk_config.svh */
`ifndef CLK_CONFIG_SVH
`define CLK_CONFIG_SVH

// Wishbone word address and data widths
`define CLK_ADDR_W 3
`define CLK_DATA_W 8

// Burst counter width, loaded in two equal halves
`define CLK_BURST_W 8

// Microcode time field width
`define CLK_TIME_W 2

// Diagnostic register word addresses
`define CLK_REG_FUNC     3'd0
`define CLK_REG_BURST_LO 3'd1
`define CLK_REG_BURST_HI 3'd2
`define CLK_REG_DIS      3'd3
`define CLK_REG_STATUS   3'd4

// Function codes in data bits 2 to 0
// Codes 3 and 4 are accepted and do nothing
`define CLK_FN_STOP      3'd0
`define CLK_FN_START     3'd1
`define CLK_FN_STEP      3'd2
`define CLK_FN_BURST     3'd5
`define CLK_FN_CLR_RESET 3'd6
`define CLK_FN_SET_RESET 3'd7

`endif

/* logic/clkPkg.sv */
`include "clk_config.svh"

package clkPkg;

  // Diagnostic bus word address
  typedef logic [`CLK_ADDR_W-1:0] wbAddrT;

  // Diagnostic bus data word
  typedef logic [`CLK_DATA_W-1:0] wbDataT;

  // Live burst count
  typedef logic [`CLK_BURST_W-1:0] burstCountT;

  // CRAM time field, MBOX clocks per EBOX clock minus three
  typedef logic [`CLK_TIME_W-1:0] cramTimeT;

  // MBOX phase counter, compared against the time field
  typedef logic [`CLK_TIME_W-1:0] phaseCountT;

  // Group disables
  // Bit 2 is CRM, bit 1 is EDP, bit 0 is CTL
  typedef logic [2:0] groupDisT;

  // Run control modes
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    BURST,
    STEP
  } runModeT;

  // Sync detector states
  typedef enum logic [1:0] {
    COUNT,
    SYNC,
    FIRE
  } syncStateT;

endpackage

/* logic/clkDiagPort.sv */
`include "clk_config.svh"

module clkDiagPort (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  // Wishbone classic slave
  input  logic               wbCyc,
  input  logic               wbStb,
  input  logic               wbWe,
  input  clkPkg::wbAddrT     wbAdr,
  input  clkPkg::wbDataT     wbDatW,
  output clkPkg::wbDataT     wbDatR,
  output logic               wbAck,
  // Live status for read-back
  input  clkPkg::burstCountT burstCount,
  input  logic               running,
  input  logic               mrReset,
  input  logic               sync,
  // Group disable register
  output clkPkg::groupDisT   groupDis,
  // One-hot function pulses
  output logic               fnStop,
  output logic               fnStart,
  output logic               fnStep,
  output logic               fnBurst,
  output logic               fnClrReset,
  output logic               fnSetReset,
  // Burst count nibble loads
  output logic               burstLoadLo,
  output logic               burstLoadHi,
  output logic [`CLK_BURST_W/2-1:0] burstData
);

  localparam int NibW = `CLK_BURST_W / 2;

  logic wrAck;
  logic funcWrite;
  logic burstZero;

  // One wait state
  // Ack rises the cycle after a new request is seen and drops after one cycle
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= wbCyc & wbStb & ~wbAck;
    end
  end

  // Master holds the request through ack
  // so the write takes effect in the ack cycle
  assign wrAck = wbAck & wbCyc & wbStb & wbWe;
  assign funcWrite = wrAck & (wbAdr == `CLK_REG_FUNC);

  // Function decoder
  always_comb begin
    fnStop = 1'b0;
    fnStart = 1'b0;
    fnStep = 1'b0;
    fnBurst = 1'b0;
    fnClrReset = 1'b0;
    fnSetReset = 1'b0;
    if (funcWrite) begin
      case (wbDatW[2:0])
        `CLK_FN_STOP:      fnStop = 1'b1;
        `CLK_FN_START:     fnStart = 1'b1;
        `CLK_FN_STEP:      fnStep = 1'b1;
        `CLK_FN_BURST:     fnBurst = 1'b1;
        `CLK_FN_CLR_RESET: fnClrReset = 1'b1;
        `CLK_FN_SET_RESET: fnSetReset = 1'b1;
        default: begin
          // Old EBOX single step codes land here
        end
      endcase
    end
  end

  // Burst count halves come from the low nibble of the data
  assign burstLoadLo = wrAck & (wbAdr == `CLK_REG_BURST_LO);
  assign burstLoadHi = wrAck & (wbAdr == `CLK_REG_BURST_HI);
  assign burstData = wbDatW[NibW-1:0];

  // EBOX clock group disables
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      groupDis <= '0;
    end else if (wrAck && (wbAdr == `CLK_REG_DIS)) begin
      groupDis <= wbDatW[2:0];
    end
  end

  assign burstZero = (burstCount == '0);

  // Read mux
  // Valid whenever the address is held, sampled by the master on ack
  always_comb begin
    wbDatR = '0;
    case (wbAdr)
      `CLK_REG_BURST_LO: wbDatR[NibW-1:0] = burstCount[NibW-1:0];
      `CLK_REG_BURST_HI: wbDatR[NibW-1:0] = burstCount[`CLK_BURST_W-1:NibW];
      `CLK_REG_DIS:      wbDatR[2:0] = groupDis;
      `CLK_REG_STATUS:   wbDatR[3:0] = {sync, mrReset, burstZero, running};
      // FUNC and unused addresses read as zero
      default:           wbDatR = '0;
    endcase
  end

endmodule

/* logic/clkRunControl.sv */
`include "clk_config.svh"

module clkRunControl (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  // Function pulses from the diagnostic port
  input  logic               fnStop,
  input  logic               fnStart,
  input  logic               fnStep,
  input  logic               fnBurst,
  input  logic               fnClrReset,
  input  logic               fnSetReset,
  // Burst count nibble loads
  input  logic               burstLoadLo,
  input  logic               burstLoadHi,
  input  logic [`CLK_BURST_W/2-1:0] burstData,
  // EBOX clock consumed by the current mode
  input  logic               eboxClk,
  output logic               running,
  output logic               mrReset,
  output clkPkg::burstCountT burstCount
);

  localparam int NibW = `CLK_BURST_W / 2;

  clkPkg::runModeT mode;
  logic countZero;
  logic lastBurst;

  assign countZero = (burstCount == '0);
  // This EBOX clock takes the count to zero
  assign lastBurst = eboxClk & (burstCount == clkPkg::burstCountT'(1));

  // Machine reset flip-flop
  // Comes up set so the machine waits for a clear reset command
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (fnSetReset) begin
      mrReset <= 1'b1;
    end else if (fnClrReset) begin
      mrReset <= 1'b0;
    end
  end

  // Mode FSM
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mode <= clkPkg::IDLE;
    end else if (fnStop) begin
      mode <= clkPkg::IDLE;
    end else if (fnStart) begin
      mode <= clkPkg::RUN;
    end else if (fnStep) begin
      mode <= clkPkg::STEP;
    end else if (fnBurst && !countZero) begin
      // Zero count burst is dropped
      mode <= clkPkg::BURST;
    end else begin
      case (mode)
        clkPkg::BURST: if (countZero || lastBurst) mode <= clkPkg::IDLE;
        clkPkg::STEP:  if (eboxClk) mode <= clkPkg::IDLE;
        default:       mode <= mode;
      endcase
    end
  end

  // Burst counter
  // Counts down on each EBOX clock, loads locked out while bursting
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (mode == clkPkg::BURST) begin
      if (eboxClk && !countZero) burstCount <= burstCount - 1'b1;
    end else begin
      if (burstLoadLo) burstCount[NibW-1:0] <= burstData;
      if (burstLoadHi) burstCount[`CLK_BURST_W-1:NibW] <= burstData;
    end
  end

  // Clock advance permission
  // STEP drops out on the cycle after its one EBOX clock
  always_comb begin
    running = 1'b0;
    if (!mrReset) begin
      case (mode)
        clkPkg::RUN:   running = 1'b1;
        clkPkg::BURST: running = !countZero;
        clkPkg::STEP:  running = 1'b1;
        default:       running = 1'b0;
      endcase
    end
  end

endmodule

/* logic/clkSyncDetect.sv */
module clkSyncDetect (
  input  logic             MBOX_CLK,
  input  logic             CLK,
  // Permission to advance from run control
  input  logic             running,
  // CRAM time field
  input  clkPkg::cramTimeT cramTime,
  // MBOX busy, holds the sync point
  input  logic             mboxWait,
  input  clkPkg::groupDisT groupDis,
  output logic             sync,
  output logic             eboxClk,
  // Per group EBOX clock enables
  output logic             clkCrm,
  output logic             clkEdp,
  output logic             clkCtl
);

  clkPkg::syncStateT state;
  clkPkg::phaseCountT phase;
  logic phaseMatch;

  // Phase counter has reached the time field
  assign phaseMatch = (phase == cramTime);

  // Sync FSM and phase counter
  // COUNT runs cramTime+1 cycles, then one SYNC and one FIRE
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      state <= clkPkg::COUNT;
      phase <= '0;
    end else begin
      case (state)
        clkPkg::COUNT: begin
          // Counter holds while stopped
          if (running) begin
            phase <= phase + 1'b1;
            if (phaseMatch) state <= clkPkg::SYNC;
          end
        end
        clkPkg::SYNC: begin
          if (!running) begin
            // Stopped at the sync point, give up without firing
            state <= clkPkg::COUNT;
          end else if (!mboxWait) begin
            state <= clkPkg::FIRE;
          end
        end
        clkPkg::FIRE: begin
          // Start the next EBOX cycle from phase zero
          phase <= '0;
          state <= clkPkg::COUNT;
        end
        default: begin
          state <= clkPkg::COUNT;
        end
      endcase
    end
  end

  // Sync is high one stage before the EBOX clock
  assign sync = (state == clkPkg::SYNC);

  // EBOX clock is a one cycle enable
  // Suppressed if run permission went away this cycle
  assign eboxClk = (state == clkPkg::FIRE) & running;

  // Group gating
  assign clkCrm = eboxClk & ~groupDis[2];
  assign clkEdp = eboxClk & ~groupDis[1];
  assign clkCtl = eboxClk & ~groupDis[0];

endmodule

/* logic/clkBoard.sv */
`include "clk_config.svh"

module clkBoard (
  input  logic             MBOX_CLK,
  input  logic             CLK,
  // Wishbone classic diagnostic port
  input  logic             wbCyc,
  input  logic             wbStb,
  input  logic             wbWe,
  input  clkPkg::wbAddrT   wbAdr,
  input  clkPkg::wbDataT   wbDatW,
  output clkPkg::wbDataT   wbDatR,
  output logic             wbAck,
  // From the CRAM and MBOX
  input  clkPkg::cramTimeT cramTime,
  input  logic             mboxWait,
  // EBOX clock enables and status
  output logic             eboxClk,
  output logic             clkCrm,
  output logic             clkEdp,
  output logic             clkCtl,
  output logic             sync,
  output logic             mrReset
);

  // Diagnostic port to run control
  logic fnStop;
  logic fnStart;
  logic fnStep;
  logic fnBurst;
  logic fnClrReset;
  logic fnSetReset;
  logic burstLoadLo;
  logic burstLoadHi;
  logic [`CLK_BURST_W/2-1:0] burstData;

  // Run control back to status and sync detector
  clkPkg::burstCountT burstCount;
  logic running;

  // Disable register to the group gates
  clkPkg::groupDisT groupDis;

  clkDiagPort clkDiagPort_inst (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .burstCount(burstCount), .running(running), .mrReset(mrReset), .sync(sync),
    .groupDis(groupDis),
    .fnStop(fnStop), .fnStart(fnStart), .fnStep(fnStep), .fnBurst(fnBurst),
    .fnClrReset(fnClrReset), .fnSetReset(fnSetReset),
    .burstLoadLo(burstLoadLo), .burstLoadHi(burstLoadHi), .burstData(burstData)
  );

  clkRunControl clkRunControl_inst (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK),
    .fnStop(fnStop), .fnStart(fnStart), .fnStep(fnStep), .fnBurst(fnBurst),
    .fnClrReset(fnClrReset), .fnSetReset(fnSetReset),
    .burstLoadLo(burstLoadLo), .burstLoadHi(burstLoadHi), .burstData(burstData),
    .eboxClk(eboxClk),
    .running(running), .mrReset(mrReset), .burstCount(burstCount)
  );

  clkSyncDetect clkSyncDetect_inst (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK),
    .running(running), .cramTime(cramTime), .mboxWait(mboxWait),
    .groupDis(groupDis),
    .sync(sync), .eboxClk(eboxClk),
    .clkCrm(clkCrm), .clkEdp(clkEdp), .clkCtl(clkCtl)
  );

endmodule

/* verif/clkBoard_props.sv */
module clkBoard_props (
  input logic MBOX_CLK,
  input logic CLK,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck,
  input logic eboxClk,
  input logic clkCrm,
  input logic clkEdp,
  input logic clkCtl,
  input logic mrReset
);
  timeunit 1ns;
  timeprecision 1ps;

  // Running total of failed properties
  int failCount = 0;

  // Ack answers a request seen on the previous edge
  ackFollowsReq: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    wbAck |-> $past(wbCyc && wbStb))
    else begin
      $error("wbAck without a preceding cyc and stb");
      failCount++;
    end

  // Single cycle ack
  ackOneCycle: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    wbAck |=> !wbAck)
    else begin
      $error("wbAck held for two cycles");
      failCount++;
    end

  // Group clocks are gated copies of the EBOX clock
  groupImpliesEbox: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (clkCrm || clkEdp || clkCtl) |-> eboxClk)
    else begin
      $error("Group clock without eboxClk");
      failCount++;
    end

  // Machine held in reset
  noClkInReset: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    mrReset |-> !eboxClk)
    else begin
      $error("eboxClk while mrReset is set");
      failCount++;
    end

  // At least SYNC and FIRE between EBOX clocks
  noBackToBack: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    eboxClk |=> !eboxClk)
    else begin
      $error("eboxClk in two consecutive cycles");
      failCount++;
    end

endmodule

bind clkBoard clkBoard_props clkBoard_props_inst (
  .MBOX_CLK(MBOX_CLK),
  .CLK(CLK),
  .wbCyc(wbCyc),
  .wbStb(wbStb),
  .wbAck(wbAck),
  .eboxClk(eboxClk),
  .clkCrm(clkCrm),
  .clkEdp(clkEdp),
  .clkCtl(clkCtl),
  .mrReset(mrReset)
);

/* verif/clkBoardTb.sv */
module clkBoardTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxVec = 64;
  localparam int CycPerVec = 40;
  localparam clkPkg::wbAddrT StatusAdr = 3'd4;

  logic MBOX_CLK;
  logic CLK;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  clkPkg::wbAddrT wbAdr;
  clkPkg::wbDataT wbDatW;
  clkPkg::wbDataT wbDatR;
  logic wbAck;
  clkPkg::cramTimeT cramTime;
  logic mboxWait;
  logic eboxClk;
  logic clkCrm;
  logic clkEdp;
  logic clkCtl;
  logic sync;
  logic mrReset;

  // Four words per vector line
  logic [7:0] vecMem [0:4*MaxVec-1];
  int numVec;
  int cycleCount;
  int cycleLimit;
  // Pulse totals, index 0 ebox, 1 crm, 2 edp, 3 ctl
  int pulseCnt [0:3];
  int pulseBase [0:3];

  clkBoard clkBoard_inst (
    .MBOX_CLK(MBOX_CLK), .CLK(CLK),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .cramTime(cramTime), .mboxWait(mboxWait),
    .eboxClk(eboxClk), .clkCrm(clkCrm), .clkEdp(clkEdp), .clkCtl(clkCtl),
    .sync(sync), .mrReset(mrReset)
  );

  initial begin
    MBOX_CLK = 1'b0;
    forever #50 MBOX_CLK = ~MBOX_CLK;
  end

  // Pulse counters, settled values read on the falling edge
  always @(posedge MBOX_CLK) begin
    if (eboxClk) pulseCnt[0] <= pulseCnt[0] + 1;
    if (clkCrm) pulseCnt[1] <= pulseCnt[1] + 1;
    if (clkEdp) pulseCnt[2] <= pulseCnt[2] + 1;
    if (clkCtl) pulseCnt[3] <= pulseCnt[3] + 1;
  end

  // Watchdog
  always @(posedge MBOX_CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycleCount);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  // Any failed property in the bound checker ends the run
  always @(negedge MBOX_CLK) begin
    if (clkBoard_inst.clkBoard_props_inst.failCount != 0) begin
      $display("A bound assertion on the DUT failed at %0t", $time);
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failed");
    end
  end

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  // One Wishbone classic cycle, request held until ack
  task automatic wbAccess(input logic we, input clkPkg::wbAddrT adr,
                          input clkPkg::wbDataT dat, output clkPkg::wbDataT rdat);
    @(posedge MBOX_CLK);
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe <= we;
    wbAdr <= adr;
    wbDatW <= dat;
    // Ack and read data seen as they were in the ack cycle
    do @(posedge MBOX_CLK); while (wbAck !== 1'b1);
    rdat = wbDatR;
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe <= 1'b0;
  endtask

  // Poll STATUS until the running bit drops
  task automatic waitIdle();
    clkPkg::wbDataT st;
    st = 8'h01;
    while (st[0] !== 1'b0) begin
      wbAccess(1'b0, StatusAdr, 8'h00, st);
    end
  endtask

  initial begin
    clkPkg::wbDataT rdat;
    logic [7:0] op;
    logic [7:0] adr;
    logic [7:0] dat;
    logic [7:0] expv;
    int stallCyc;
    int snap;
    void'($urandom(32'hd060));
    CLK = 1'b1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    cramTime = '0;
    mboxWait = 1'b0;
    cycleCount = 0;
    pulseCnt = '{0, 0, 0, 0};
    pulseBase = '{0, 0, 0, 0};
    $readmemh("verif/clkBoard_vectors.txt", vecMem);
    numVec = 0;
    while (numVec < MaxVec && vecMem[4*numVec] !== 8'h0f && !$isunknown(vecMem[4*numVec]))
      numVec++;
    cycleLimit = CycPerVec * (numVec + 1);
    if (numVec == 0) begin
      $display("No stimulus lines could be read from the vector file");
      $display("RESULT: FAIL");
      $fatal(1, "Missing vectors");
    end
    repeat (4) @(posedge MBOX_CLK);
    CLK <= 1'b0;
    for (int i = 0; i < numVec; i++) begin
      op = vecMem[4*i];
      adr = vecMem[4*i+1];
      dat = vecMem[4*i+2];
      expv = vecMem[4*i+3];
      case (op)
        8'h0: wbAccess(1'b1, adr[2:0], dat, rdat);
        8'h1: begin
          wbAccess(1'b0, adr[2:0], 8'h00, rdat);
          checkEq(32'(rdat), 32'(expv), $sformatf("read of register %0d", adr));
          // Status outputs on the top level agree with the STATUS bits
          if (adr[2:0] == StatusAdr) begin
            checkEq(32'(mrReset), 32'(expv[2]), "mrReset output");
            checkEq(32'(sync), 32'(expv[3]), "sync output");
          end
        end
        8'h2: begin
          waitIdle();
          @(negedge MBOX_CLK);
          checkEq(pulseCnt[0] - pulseBase[0], 32'(expv), "eboxClk pulses of the run");
        end
        8'h3: begin
          @(posedge MBOX_CLK);
          cramTime <= dat[1:0];
          mboxWait <= dat[4];
          @(negedge MBOX_CLK);
          pulseBase = pulseCnt;
        end
        8'h4: begin
          stallCyc = 5 + int'($urandom % 11);
          // MBOX already busy, wait for the sync point
          while (sync !== 1'b1) @(negedge MBOX_CLK);
          snap = pulseCnt[0];
          // Running, sync set, count not zero
          wbAccess(1'b0, StatusAdr, 8'h00, rdat);
          checkEq(32'(rdat), 32'h09, "STATUS during MBOX wait");
          repeat (stallCyc - 3) @(posedge MBOX_CLK);
          @(negedge MBOX_CLK);
          checkEq(pulseCnt[0], snap, "eboxClk pulses during MBOX wait");
          @(posedge MBOX_CLK);
          mboxWait <= 1'b0;
        end
        8'h5: begin
          repeat (dat) @(posedge MBOX_CLK);
          @(negedge MBOX_CLK);
          checkEq(pulseCnt[adr[1:0]] - pulseBase[adr[1:0]], 32'(expv),
                  $sformatf("pulse count of output %0d", adr));
        end
        8'h6: begin
          @(negedge MBOX_CLK);
          snap = pulseCnt[0];
          checkEq(32'(snap > pulseBase[0]), 32'h1, "eboxClk pulses before stop");
          repeat (dat) @(posedge MBOX_CLK);
          @(negedge MBOX_CLK);
          checkEq(pulseCnt[0], snap, "eboxClk pulses after stop");
        end
        8'h7: repeat (dat) @(posedge MBOX_CLK);
        default: begin
          $display("Vector line %0d holds an unknown operation %0h", i, op);
          $display("RESULT: FAIL");
          $fatal(1, "Bad vector");
        end
      endcase
    end
    if (clkBoard_inst.clkBoard_props_inst.failCount != 0) begin
      $display("A bound assertion on the DUT failed");
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+logic
logic/clkPkg.sv
logic/clkDiagPort.sv
logic/clkRunControl.sv
logic/clkSyncDetect.sv
logic/clkBoard.sv
verif/clkBoard_props.sv
verif/clkBoardTb.sv

/* verif/clkBoard_vectors.txt */
// Columns: op addr data expect, all hex, one operation per line
// op 0 write, 1 read and expect, 2 wait for running clear then expect eboxClk count
// op 3 set cramTime from data[1:0] and mboxWait from data[4], 4 MBOX wait stall check
// op 5 idle data cycles then expect count (addr 0 ebox 1 crm 2 edp 3 ctl)
// op 6 count frozen for data cycles, 7 idle data cycles, f end
1 4 00 06
1 1 00 00
1 2 00 00
1 3 00 00
0 0 01 00
5 0 14 00
0 0 00 00
0 0 06 00
0 1 05 00
0 2 02 00
1 1 00 05
1 2 00 02
1 4 00 00
3 0 01 00
0 0 05 00
2 0 00 25
1 1 00 00
1 2 00 00
1 4 00 02
3 0 00 00
0 1 05 00
0 2 02 00
0 0 05 00
2 0 00 25
3 0 03 00
0 1 05 00
0 2 02 00
0 0 05 00
2 0 00 25
1 4 00 02
3 0 01 00
0 0 02 00
2 0 00 01
3 0 01 00
0 0 01 00
7 0 10 00
0 0 00 00
6 0 14 00
0 3 02 00
1 3 00 02
3 0 01 00
0 1 04 00
0 2 00 00
0 0 05 00
2 0 00 04
5 1 00 04
5 2 00 00
5 3 00 04
3 0 11 00
0 1 03 00
0 2 00 00
0 0 05 00
4 0 00 00
2 0 00 03
f 0 00 00
